// ==== tb.f ====
source/icachePkg.sv
source/cacheWay.sv
source/icacheController.sv
source/instrCache.sv
bench/busMemory.sv
bench/instrCacheTb.sv

// ==== bench/instrCacheTb.sv ====
`timescale 1ns/1ps
// Testbench for the instruction cache; memory returns ~address for every word
// Fetch addresses in the table are word aligned, so expected instr is ~fetchAddr

module instrCacheTb;

  localparam int clkPeriod = 8;
  localparam int fetchTimeout = 64;

  logic clk;
  logic reset;
  logic fetchReq;
  icachePkg::wordT fetchAddr;
  logic cacheEnable;
  icachePkg::wordT instr;
  logic instrValid;
  logic memReq;
  icachePkg::wordT memAddr;
  logic memReady;
  icachePkg::wordT memData;
  int transferCount;

  // Stimulus table
  icachePkg::wordT tableAddr[$];
  logic tableEnable[$];
  int tableXfers[$];
  logic tableReset[$];

  // Addresses of the transfers of the current entry
  icachePkg::wordT seenAddr[$];

  int errorCount;
  int passCount;
  int failCount;

  instrCache instrCache_i (
    .clk         (clk),
    .reset       (reset),
    .fetchReq    (fetchReq),
    .fetchAddr   (fetchAddr),
    .cacheEnable (cacheEnable),
    .instr       (instr),
    .instrValid  (instrValid),
    .memReq      (memReq),
    .memAddr     (memAddr),
    .memReady    (memReady),
    .memData     (memData)
  );

  busMemory memory (
    .clk           (clk),
    .reset         (reset),
    .memReq        (memReq),
    .memAddr       (memAddr),
    .memReady      (memReady),
    .memData       (memData),
    .transferCount (transferCount)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Log every bus transfer
  always @(posedge clk) begin
    if (memReq && memReady) begin
      seenAddr.push_back(memAddr);
    end
  end

  task automatic addEntry(input icachePkg::wordT addr, input logic enable,
                          input int xfers, input logic resetFirst);
    tableAddr.push_back(addr);
    tableEnable.push_back(enable);
    tableXfers.push_back(xfers);
    tableReset.push_back(resetFirst);
  endtask

  // Holds reset over three rising edges, returns on a falling edge
  task automatic applyReset();
    reset = 1'b1;
    fetchReq = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #(clkPeriod / 2 - 1);
    assert (!memReq && !instrValid) else begin
      $display("mismatch at %0t ns: memReq %b instrValid %b after reset", $time,
               memReq, instrValid);
      errorCount++;
    end
    @(negedge clk);
  endtask

  // One fetch, from a falling edge to a falling edge
  task automatic runFetch(input int entry, output bit timedOut);
    icachePkg::wordT addr;
    icachePkg::wordT lineBase;
    logic enable;
    int expXfers;
    int startCount;
    int gotXfers;
    int waited;
    int errorsBefore;

    addr = tableAddr[entry];
    enable = tableEnable[entry];
    expXfers = tableXfers[entry];
    lineBase = addr & 32'hFFFF_FFF0;
    errorsBefore = errorCount;
    timedOut = 1'b0;
    seenAddr.delete();
    startCount = transferCount;

    fetchAddr = addr;
    cacheEnable = enable;
    fetchReq = 1'b1;
    waited = 0;
    // Sample just before the rising edge
    #(clkPeriod / 2 - 1);
    while (!instrValid && waited < fetchTimeout) begin
      @(negedge clk);
      waited++;
      #(clkPeriod / 2 - 1);
    end

    if (!instrValid) begin
      $display("entry %0d: no instrValid within %0d cycles for address %h", entry,
               fetchTimeout, addr);
      timedOut = 1'b1;
      fetchReq = 1'b0;
    end else begin
      assert (instr == ~addr) else begin
        $display("mismatch at %0t ns: entry %0d instr %h, expected %h", $time, entry,
                 instr, ~addr);
        errorCount++;
      end
      if (enable && expXfers == 0) begin
        // A hit answers in the request cycle
        assert (waited == 0) else begin
          $display("mismatch at %0t ns: entry %0d hit took %0d extra cycles", $time,
                   entry, waited);
          errorCount++;
        end
      end

      @(negedge clk);
      fetchReq = 1'b0;
      #(clkPeriod / 2 - 1);
      assert (!instrValid) else begin
        $display("mismatch at %0t ns: entry %0d instrValid high after fetchReq dropped",
                 $time, entry);
        errorCount++;
      end

      gotXfers = transferCount - startCount;
      assert (gotXfers == expXfers) else begin
        $display("mismatch at %0t ns: entry %0d made %0d transfers, expected %0d", $time,
                 entry, gotXfers, expXfers);
        errorCount++;
      end

      // Refill walks the line from word 0, bypass reads the fetch address
      if (seenAddr.size() == expXfers) begin
        for (int k = 0; k < seenAddr.size(); k++) begin
          assert (seenAddr[k] == ((expXfers == 1) ? addr : lineBase + 32'(4 * k))) else begin
            $display("mismatch at %0t ns: entry %0d transfer %0d at %h", $time, entry, k,
                     seenAddr[k]);
            errorCount++;
          end
        end
      end
      @(negedge clk);
    end

    if (errorCount == errorsBefore && !timedOut) begin
      passCount++;
      $display("entry %0d addr %h enable %0d transfers %0d: ok", entry, addr, enable,
               expXfers);
    end else begin
      failCount++;
      $display("entry %0d addr %h enable %0d transfers %0d: FAILED", entry, addr, enable,
               expXfers);
    end
  endtask

  initial begin
    int idx;
    bit timedOut;

    reset = 1'b1;
    fetchReq = 1'b0;
    fetchAddr = '0;
    cacheEnable = 1'b1;
    errorCount = 0;
    passCount = 0;
    failCount = 0;
    timedOut = 1'b0;

    // Lines A, B, C share set 5
    addEntry(32'h0000_1050, 1'b1, 4, 1'b0);
    addEntry(32'h0000_1058, 1'b1, 0, 1'b0);
    addEntry(32'h0000_105C, 1'b1, 0, 1'b0);
    addEntry(32'h0000_2054, 1'b1, 4, 1'b0);
    addEntry(32'h0000_1050, 1'b1, 0, 1'b0);
    // A was used last, so C replaces B
    addEntry(32'h0000_3050, 1'b1, 4, 1'b0);
    addEntry(32'h0000_1054, 1'b1, 0, 1'b0);
    addEntry(32'h0000_2050, 1'b1, 4, 1'b0);
    addEntry(32'h0000_3058, 1'b1, 4, 1'b0);
    addEntry(32'h0000_1050, 1'b1, 4, 1'b0);
    // Bypass leaves the arrays alone
    addEntry(32'h0000_4120, 1'b0, 1, 1'b0);
    addEntry(32'h0000_4120, 1'b1, 4, 1'b0);
    addEntry(32'h0000_4124, 1'b1, 0, 1'b0);
    addEntry(32'h0000_4128, 1'b0, 1, 1'b0);
    addEntry(32'h0001_00F0, 1'b1, 4, 1'b0);
    addEntry(32'h0001_00F4, 1'b1, 0, 1'b0);
    addEntry(32'hFFFF_FFF0, 1'b1, 4, 1'b0);
    addEntry(32'hFFFF_FFFC, 1'b1, 0, 1'b0);
    // Cached lines are gone after reset
    addEntry(32'h0000_4124, 1'b1, 4, 1'b1);
    addEntry(32'h0000_412C, 1'b1, 0, 1'b0);
    addEntry(32'h0000_1050, 1'b1, 4, 1'b0);
    addEntry(32'h0000_1054, 1'b1, 0, 1'b0);

    applyReset();

    idx = 0;
    while (idx < tableAddr.size() && !timedOut) begin
      if (tableReset[idx]) begin
        applyReset();
      end
      runFetch(idx, timedOut);
      idx++;
    end

    $display("entries %0d passed %0d failed %0d errors %0d", idx, passCount, failCount,
             errorCount);
    if (errorCount == 0 && failCount == 0 && !timedOut) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== bench/busMemory.sv ====
`timescale 1ns/1ps
// Behavioral instruction memory; the word at byte address A reads as ~A
// memReady drops for 0 to 3 cycles after each transfer, chosen by an LFSR

module busMemory (
  input  logic             clk,
  input  logic             reset,
  input  logic             memReq,
  input  icachePkg::wordT  memAddr,
  output logic             memReady,
  output icachePkg::wordT  memData,
  output int               transferCount
);

  localparam logic [15:0] lfsrSeed = 16'd6174;

  logic [15:0] lfsr;
  logic [15:0] stepOne;
  logic [15:0] stepTwo;
  logic [1:0] gapLeft;

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] nextLfsr(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // Two steps, one per gap bit
  assign stepOne = nextLfsr(lfsr);
  assign stepTwo = nextLfsr(stepOne);

  assign memData = ~memAddr;

  // Transfer count and gap length after each beat
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lfsr <= lfsrSeed;
      gapLeft <= 2'd0;
      transferCount <= 0;
    end else if (memReq && memReady) begin
      transferCount <= transferCount + 1;
      gapLeft <= {stepOne[0], stepTwo[0]};
      lfsr <= stepTwo;
    end else if (!memReady && gapLeft != 2'd0) begin
      gapLeft <= gapLeft - 2'd1;
    end
  end

  // Ready changes on the falling edge like every other bench input
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      memReady <= 1'b0;
    end else begin
      memReady <= (gapLeft == 2'd0);
    end
  end

endmodule

// ==== source/instrCache.sv ====
`timescale 1ns/1ps
// Two-way set-associative instruction cache, 64 sets of four-word lines
// Bus handshake holds memReq until memReady for each word; no writes

module instrCache (
  input  logic             clk,
  input  logic             reset,
  input  logic             fetchReq,
  input  icachePkg::wordT  fetchAddr,
  input  logic             cacheEnable,
  output icachePkg::wordT  instr,
  output logic             instrValid,
  output logic             memReq,
  output icachePkg::wordT  memAddr,
  input  logic             memReady,
  input  icachePkg::wordT  memData
);

  // Address fields shared by both ways
  icachePkg::setIndexT index;
  icachePkg::tagT lookupTag;

  // Way results
  logic way0Hit;
  logic way1Hit;
  logic way0Valid;
  logic way1Valid;
  icachePkg::wordT way0Data;
  icachePkg::wordT way1Data;

  // Controller to ways
  icachePkg::wordSelT wordSel;
  logic way0Fill;
  logic way1Fill;
  logic fillLast;

  assign lookupTag = fetchAddr[icachePkg::wordWidth-1 -: icachePkg::tagWidth];
  assign index = fetchAddr[icachePkg::wordWidth-icachePkg::tagWidth-1 -: icachePkg::indexWidth];

  cacheWay way0 (
    .clk       (clk),
    .reset     (reset),
    .index     (index),
    .lookupTag (lookupTag),
    .wordSel   (wordSel),
    .fillData  (memData),
    .fill      (way0Fill),
    .fillLast  (fillLast),
    .wayHit    (way0Hit),
    .wayValid  (way0Valid),
    .readData  (way0Data)
  );

  cacheWay way1 (
    .clk       (clk),
    .reset     (reset),
    .index     (index),
    .lookupTag (lookupTag),
    .wordSel   (wordSel),
    .fillData  (memData),
    .fill      (way1Fill),
    .fillLast  (fillLast),
    .wayHit    (way1Hit),
    .wayValid  (way1Valid),
    .readData  (way1Data)
  );

  icacheController ctrl (
    .clk         (clk),
    .reset       (reset),
    .fetchReq    (fetchReq),
    .fetchAddr   (fetchAddr),
    .cacheEnable (cacheEnable),
    .way0Hit     (way0Hit),
    .way1Hit     (way1Hit),
    .way0Valid   (way0Valid),
    .way1Valid   (way1Valid),
    .way0Data    (way0Data),
    .way1Data    (way1Data),
    .memReady    (memReady),
    .memData     (memData),
    .instr       (instr),
    .instrValid  (instrValid),
    .memReq      (memReq),
    .memAddr     (memAddr),
    .wordSel     (wordSel),
    .way0Fill    (way0Fill),
    .way1Fill    (way1Fill),
    .fillLast    (fillLast)
  );

endmodule

// ==== source/icacheController.sv ====
`timescale 1ns/1ps
// Fetch controller of the two-way instruction cache
// One fetch at a time; refill starts at word 0 and takes four memory beats
// The beat that starts a refill may already transfer in the lookup cycle

module icacheController (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fetchReq,
  input  icachePkg::wordT      fetchAddr,
  input  logic                 cacheEnable,
  input  logic                 way0Hit,
  input  logic                 way1Hit,
  input  logic                 way0Valid,
  input  logic                 way1Valid,
  input  icachePkg::wordT      way0Data,
  input  icachePkg::wordT      way1Data,
  input  logic                 memReady,
  input  icachePkg::wordT      memData,
  output icachePkg::wordT      instr,
  output logic                 instrValid,
  output logic                 memReq,
  output icachePkg::wordT      memAddr,
  output icachePkg::wordSelT   wordSel,
  output logic                 way0Fill,
  output logic                 way1Fill,
  output logic                 fillLast
);

  // FSM state
  icachePkg::fetchStateT state;
  icachePkg::fetchStateT nextState;

  // Fetch address fields
  icachePkg::setIndexT fetchIndex;
  icachePkg::wordSelT fetchWord;

  // Refill bookkeeping
  icachePkg::wordSelT beatCount;
  logic victimNow;
  logic victimWay;
  logic fillWay;

  // One LRU bit per set, holding the way to replace next
  logic [icachePkg::numSets-1:0] lruBits;

  // Decoded conditions
  logic anyHit;
  logic lookupActive;
  logic hitDone;
  logic startRefill;
  logic startBypass;
  logic refillReq;
  logic bypassReq;
  logic beatDone;
  logic lastBeat;

  // Index sits just below the tag, the word offset just below the index
  assign fetchIndex = fetchAddr[icachePkg::wordWidth-icachePkg::tagWidth-1 -: icachePkg::indexWidth];
  assign fetchWord = fetchAddr[icachePkg::wordWidth-icachePkg::tagWidth-icachePkg::indexWidth-1
                               -: icachePkg::offsetWidth];

  // Combined hit of both ways
  assign anyHit = way0Hit | way1Hit;

  // A pending fetch is only acted on in lookup
  assign lookupActive = (state == icachePkg::lookup) && fetchReq;
  assign hitDone = lookupActive && cacheEnable && anyHit;
  assign startRefill = lookupActive && cacheEnable && !anyHit;
  assign startBypass = lookupActive && !cacheEnable;

  // Memory request is raised in the cycle the miss is seen
  assign refillReq = startRefill || (state == icachePkg::refill);
  assign bypassReq = startBypass || (state == icachePkg::bypass);

  // Beat accounting
  assign beatDone = refillReq && memReady;
  assign lastBeat = beatDone &&
                    (beatCount == icachePkg::wordSelT'(icachePkg::lineWords - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= icachePkg::lookup;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      icachePkg::lookup: begin
        if (startRefill) begin
          nextState = icachePkg::refill;
        end else if (startBypass && !memReady) begin
          // Single word not ready yet, keep asking
          nextState = icachePkg::bypass;
        end
      end
      icachePkg::refill: begin
        if (lastBeat) begin
          nextState = icachePkg::settle;
        end
      end
      icachePkg::settle: begin
        nextState = icachePkg::lookup;
      end
      icachePkg::bypass: begin
        if (memReady) begin
          nextState = icachePkg::lookup;
        end
      end
      default: begin
        nextState = icachePkg::lookup;
      end
    endcase
  end

  // Beat counter, wraps back to 0 after the fourth beat
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      beatCount <= '0;
    end else if (beatDone) begin
      beatCount <= beatCount + 1'b1;
    end
  end

  // Invalid way first, otherwise the LRU way of the set
  always_comb begin
    if (!way0Valid) begin
      victimNow = 1'b0;
    end else if (!way1Valid) begin
      victimNow = 1'b1;
    end else begin
      victimNow = lruBits[fetchIndex];
    end
  end

  // Victim is frozen once the refill starts, since valid bits change under it
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      victimWay <= 1'b0;
    end else if (startRefill) begin
      victimWay <= victimNow;
    end
  end

  assign fillWay = (state == icachePkg::refill) ? victimWay : victimNow;

  // LRU update on a hit: the other way becomes LRU
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (hitDone) begin
      lruBits[fetchIndex] <= way0Hit;
    end
  end

  // Fill strobes to the ways
  assign way0Fill = beatDone && !fillWay;
  assign way1Fill = beatDone && fillWay;
  assign fillLast = lastBeat;

  // Beat count addresses the line while filling
  assign wordSel = refillReq ? beatCount : fetchWord;

  // Memory side
  assign memReq = refillReq || bypassReq;
  assign memAddr = bypassReq ? fetchAddr :
                   {fetchAddr[icachePkg::wordWidth-1:icachePkg::offsetWidth+2], beatCount, 2'b00};

  // CPU side
  assign instr = bypassReq ? memData : (way1Hit ? way1Data : way0Data);
  assign instrValid = hitDone || (bypassReq && memReady);

  // A line lives in at most one way
  oneHotHit : assert property (
    @(posedge clk) disable iff (reset)
    !(way0Hit && way1Hit)
  ) else $error("icacheController: both ways hit");

  // Request may not drop in the middle of a line fill
  refillHoldsReq : assert property (
    @(posedge clk) disable iff (reset)
    (refillReq && !lastBeat) |=> memReq
  ) else $error("icacheController: memReq dropped before the final beat");

endmodule

// ==== source/cacheWay.sv ====
`timescale 1ns/1ps
// One way of the instruction cache: tag, valid and data flops per set
// Any fill beat clears the valid bit; it is set again on the last beat only

module cacheWay (
  input  logic                 clk,
  input  logic                 reset,
  input  icachePkg::setIndexT  index,
  input  icachePkg::tagT       lookupTag,
  input  icachePkg::wordSelT   wordSel,
  input  icachePkg::wordT      fillData,
  input  logic                 fill,
  input  logic                 fillLast,
  output logic                 wayHit,
  output logic                 wayValid,
  output icachePkg::wordT      readData
);

  // Storage arrays
  icachePkg::tagT tagMem [icachePkg::numSets];
  icachePkg::wordT dataMem [icachePkg::numSets][icachePkg::lineWords];
  logic [icachePkg::numSets-1:0] validBits;

  // Values of the indexed set
  icachePkg::tagT storedTag;
  logic storedValid;

  assign storedTag = tagMem[index];
  assign storedValid = validBits[index];

  // Valid flag per set
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validBits <= '0;
    end else if (fill) begin
      // A partly written line must not hit
      validBits[index] <= fillLast;
    end
  end

  // Tag is rewritten on every beat of the fill
  always_ff @(posedge clk) begin
    if (fill) begin
      tagMem[index] <= lookupTag;
    end
  end

  // One data word per beat, addressed by the beat count
  always_ff @(posedge clk) begin
    if (fill) begin
      dataMem[index][wordSel] <= fillData;
    end
  end

  // Tag compare
  assign wayValid = storedValid;
  assign wayHit = storedValid && (storedTag == lookupTag);

  // Asynchronous word read
  assign readData = dataMem[index][wordSel];

  // The last-beat strobe is shared by both ways and marks the last word of the line
  lastBeatLastWord : assert property (
    @(posedge clk) disable iff (reset)
    (fill && fillLast) |-> (wordSel == icachePkg::wordSelT'(icachePkg::lineWords - 1))
  ) else $error("cacheWay: last fill beat not at the last word of the line");

  // The controller only fills a way that missed
  noFillOnHit : assert property (
    @(posedge clk) disable iff (reset)
    fill |-> !wayHit
  ) else $error("cacheWay: fill into a way that hits");

endmodule

// ==== source/icachePkg.sv ====
// Shared geometry, field types and controller states of the instruction cache
// Fetch addresses are byte addresses of aligned 32-bit words; bits 1:0 are ignored

package icachePkg;

  // Data path
  localparam int wordWidth = 32;

  // Line and set geometry
  localparam int lineWords = 4;
  localparam int numSets = 64;

  // Address fields of a fetch address
  localparam int offsetWidth = 2;
  localparam int indexWidth = 6;
  localparam int tagWidth = 22;

  // Instruction words and fetch addresses
  typedef logic [wordWidth-1:0] wordT;

  // Tag part of a fetch address, bits 31:10
  typedef logic [tagWidth-1:0] tagT;

  // Set index, bits 9:4
  typedef logic [indexWidth-1:0] setIndexT;

  // Word within a line, bits 3:2
  typedef logic [offsetWidth-1:0] wordSelT;

  // Fetch controller states
  typedef enum logic [1:0] {
    // Idle, or tag compare of a pending fetch
    lookup,
    // Line fill in progress
    refill,
    // One cycle after the last fill beat
    settle,
    // Uncached single-word read
    bypass
  } fetchStateT;

endpackage
